// File: src.f
verilog/dec_bus_pkg.sv
verilog/dec_tdm_pkg.sv
verilog/sample_fifo.sv
verilog/wb_slave_decoder.sv
verilog/tdm_rx.sv
verilog/tdm_tx.sv
verilog/irq_ctrl.sv
verilog/dec_io_top.sv
verif/dec_io_checker.sv
verif/dec_io_asserts.sv
verif/tb_dec_io.sv

// File: run.sh
#!/bin/sh
# build the decoder I/O testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module tb_dec_io -o sim_dec_io &&
./obj_dir/sim_dec_io | tee /dev/stderr | grep -q "Test OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: verif/tb_dec_io.sv
`timescale 1ns/1ps
// Decoder I/O testbench
// clock, reset, Wishbone and serial stimulus, test sequence, watchdog

module tb_dec_io import dec_bus_pkg::*, dec_tdm_pkg::*;;

	localparam int CLK_PERIOD = 40;
	// cycle budget per test, summed for the watchdog
	localparam int BUDGET_CYC = 200 + 5000 + 2500 + 3000 + 3500 + 1000 + 2000;

	logic    clk, reset;
	wb_adr_t wb_adr;
	logic    wb_we, wb_cyc, wb_stb, wb_ack, wb_err;
	wb_dat_t wb_dat, wb_rdat;
	logic    dec_s, dec_s_clk, dec_s_fs;
	logic    dec_o, dec_o_clk, dec_o_fs, irq;
	integer  seed = 32'hbbb;
	wb_dat_t rd;
	logic    r_ack, r_err;
	int      n, sent, guard;
	irq_vec_t en;

	dec_io_top dec_io_top_inst (
		.clk(clk), .i_reset(reset),
		.i_wb_adr(wb_adr), .i_wb_we(wb_we), .i_wb_dat(wb_dat),
		.i_wb_cyc(wb_cyc), .i_wb_stb(wb_stb),
		.o_wb_dat(wb_rdat), .o_wb_ack(wb_ack), .o_wb_err(wb_err),
		.i_dec_s(dec_s), .i_dec_s_clk(dec_s_clk), .i_dec_s_fs(dec_s_fs),
		.o_dec_o(dec_o), .o_dec_o_clk(dec_o_clk), .o_dec_o_fs(dec_o_fs),
		.o_irq(irq)
	);

	dec_io_checker chk_inst (
		.clk(clk), .i_reset(reset), .i_dec_o(dec_o), .i_dec_o_clk(dec_o_clk),
		.i_dec_o_fs(dec_o_fs), .i_irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(longint'(BUDGET_CYC) * CLK_PERIOD);
		$display("watchdog: run timed out after %0d cycles", BUDGET_CYC);
		$display("Test FAILED");
		$finish;
	end

	// ----------------------------------------------------------
	// bus access, response sampled mid cycle
	task automatic bus_xfer(input wb_adr_t adr, input logic we, input wb_dat_t wdat,
			output wb_dat_t rdat, output logic got_ack, output logic got_err);
		int cyc_n;
		cyc_n = 0;
		@(posedge clk);
		wb_adr <= adr;
		wb_we  <= we;
		wb_dat <= wdat;
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		do begin
			@(negedge clk);
			cyc_n++;
		end while (!(wb_ack || wb_err) && cyc_n < 16);
		if (!(wb_ack || wb_err))
			chk_inst.report_problem($sformatf("bus access to 0x%08h got no response", adr));
		rdat = wb_rdat;
		got_ack = wb_ack;
		got_err = wb_err;
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	function automatic wb_adr_t reg_adr(input logic [3:0] slv, input reg_ofs_t ofs);
		return (wb_adr_t'(slv) << SLV_SEL_LSB) | (wb_adr_t'(ofs) << REG_OFS_LSB);
	endfunction

	task automatic reg_read(input logic [3:0] slv, input reg_ofs_t ofs, output wb_dat_t d);
		logic a, e;
		bus_xfer(reg_adr(slv, ofs), 1'b0, '0, d, a, e);
	endtask

	task automatic reg_write(input logic [3:0] slv, input reg_ofs_t ofs, input wb_dat_t d);
		wb_dat_t dummy;
		logic a, e;
		bus_xfer(reg_adr(slv, ofs), 1'b1, d, dummy, a, e);
	endtask

	// one serial bit, 4 clk low then 4 clk high
	task automatic serial_bit(input logic fs, input logic d);
		@(posedge clk);
		dec_s_clk <= 1'b0;
		dec_s_fs  <= fs;
		dec_s     <= d;
		repeat (3) @(posedge clk);
		@(posedge clk);
		dec_s_clk <= 1'b1;
		repeat (3) @(posedge clk);
	endtask

	task automatic send_code(input code_t c);
		serial_bit(1'b1, 1'b0);	// frame sync
		for (int i = CODE_BITS - 1; i >= 0; i--)
			serial_bit(1'b0, c[i]);
		serial_bit(1'b0, 1'b0);	// idle bit, push settles
		chk_inst.sent_code(c);
	endtask

	task automatic check_rx_status();
		wb_dat_t d;
		reg_read(SLV_TDM_RX, REG_STATUS, d);
		chk_inst.check_value("rx status", d, chk_inst.rx_status());
	endtask

	// ----------------------------------------------------------
	// test sequence
	initial begin
		reset = 1'b1;
		wb_adr = '0;
		wb_we = 1'b0;
		wb_dat = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		dec_s = 1'b0;
		dec_s_clk = 1'b0;
		dec_s_fs = 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		chk_inst.begin_test();
		@(negedge clk);
		chk_inst.check_value("o_irq", wb_dat_t'(irq), '0);
		chk_inst.check_value("o_dec_o_fs", wb_dat_t'(dec_o_fs), '0);
		chk_inst.check_value("o_dec_o", wb_dat_t'(dec_o), '0);
		check_rx_status();
		reg_read(SLV_TDM_TX, REG_STATUS, rd);
		chk_inst.check_value("tx status", rd, '0);
		chk_inst.end_test("reset_values");

		chk_inst.begin_test();
		sent = 0;
		while (sent < 20) begin
			n = 1 + ($random(seed) & 3);	// groups of 1 to 4
			if (n > 20 - sent)
				n = 20 - sent;
			repeat (n) send_code(code_t'($random(seed)));
			sent += n;
			check_rx_status();
			repeat (n) begin
				reg_read(SLV_TDM_RX, REG_DATA, rd);
				chk_inst.check_rx_data(rd);
				check_rx_status();
			end
		end
		chk_inst.end_test("rx_path");

		chk_inst.begin_test();
		repeat (6) send_code(code_t'($random(seed)));
		check_rx_status();
		repeat (4) begin
			reg_read(SLV_TDM_RX, REG_DATA, rd);
			chk_inst.check_rx_data(rd);
		end
		check_rx_status();	// count 0, overflow still set
		reg_write(SLV_TDM_RX, REG_STATUS, '0);
		chk_inst.clear_ovf();
		check_rx_status();
		chk_inst.end_test("overflow");

		chk_inst.begin_test();
		for (int i = 0; i < 12; i++) begin
			do reg_read(SLV_TDM_TX, REG_STATUS, rd);
			while (rd >= wb_dat_t'(FIFO_DEPTH));	// wait for room
			rd = wb_dat_t'($random(seed));
			reg_write(SLV_TDM_TX, REG_DATA, rd);
			chk_inst.sent_pcm(pcm_t'(rd));
		end
		guard = 0;
		while (chk_inst.pcm_q.size() != 0 && guard < 2000) begin
			@(posedge clk);
			guard++;
		end
		repeat (20) @(posedge clk);
		chk_inst.check_value("tx words seen", wb_dat_t'(chk_inst.words_seen), 32'd12);
		reg_read(SLV_TDM_TX, REG_STATUS, rd);
		chk_inst.check_value("tx status", rd, '0);
		chk_inst.end_test("tx_path");

		chk_inst.begin_test();
		for (int ph = 0; ph < 2; ph++) begin
			if (ph == 1)
				repeat (5) send_code(code_t'($random(seed)));	// avail and overflow
			repeat (4) begin
				en = irq_vec_t'($random(seed));
				reg_write(SLV_IRQ, REG_IRQ_ENABLE, wb_dat_t'(en));
				chk_inst.set_enable(en);
				reg_read(SLV_IRQ, REG_IRQ_ENABLE, rd);
				chk_inst.check_value("irq enable", rd, wb_dat_t'(en));
				repeat (3) @(posedge clk);
				@(negedge clk);
				chk_inst.check_irq();
				reg_read(SLV_IRQ, REG_IRQ_STATUS, rd);
				chk_inst.check_value("irq status", rd, wb_dat_t'(chk_inst.sources()));
			end
		end
		repeat (4) begin
			reg_read(SLV_TDM_RX, REG_DATA, rd);
			chk_inst.check_rx_data(rd);
		end
		reg_write(SLV_TDM_RX, REG_STATUS, '0);
		chk_inst.clear_ovf();
		chk_inst.end_test("interrupts");

		chk_inst.begin_test();
		repeat (5) send_code(code_t'($random(seed)));	// full rx fifo and overflow set
		repeat (10) begin
			n = 3 + (($random(seed) & 32'h7fff_ffff) % 13);	// slaves 3..15
			bus_xfer(reg_adr(4'(n), reg_ofs_t'($random(seed))), 1'($random(seed)),
				wb_dat_t'($random(seed)), rd, r_ack, r_err);
			chk_inst.check_value("err on unmapped", wb_dat_t'(r_err), 32'd1);
			chk_inst.check_value("ack on unmapped", wb_dat_t'(r_ack), '0);
		end
		check_rx_status();
		reg_read(SLV_IRQ, REG_IRQ_ENABLE, rd);
		chk_inst.check_value("irq enable", rd, wb_dat_t'(chk_inst.en_model));
		reg_read(SLV_TDM_TX, REG_STATUS, rd);
		chk_inst.check_value("tx status", rd, '0);
		chk_inst.end_test("bus_errors");

		$display("tests %0d, failed %0d, errors %0d",
			chk_inst.tests_run, chk_inst.tests_failed, chk_inst.err_cnt);
		if (chk_inst.err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: verif/dec_io_asserts.sv
`timescale 1ns/1ps
// Wishbone response checks
// bound into the slave decoder, one response per access, one cycle long

module dec_io_asserts (
	input logic clk,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input logic i_busy,	// decoder's access in flight flag
	input logic o_wb_ack,
	input logic o_wb_err
);

	ack_err_excl: assert property (@(posedge clk) disable iff (i_reset)
		!(o_wb_ack && o_wb_err))
		else $error("ack and err high in the same cycle");

	resp_one_cycle: assert property (@(posedge clk) disable iff (i_reset)
		(o_wb_ack || o_wb_err) |=> !(o_wb_ack || o_wb_err))
		else $error("bus response held longer than one cycle");

	// new access answered on the next cycle, by exactly one of the two
	resp_next_cycle: assert property (@(posedge clk) disable iff (i_reset)
		(i_wb_cyc && i_wb_stb && !i_busy) |=> (o_wb_ack ^ o_wb_err))
		else $error("no single response one cycle after a new access");

endmodule

bind wb_slave_decoder dec_io_asserts dec_io_asserts_inst (
	.clk(clk), .i_reset(i_reset), .i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
	.i_busy(busy), .o_wb_ack(o_wb_ack), .o_wb_err(o_wb_err)
);

// File: verif/dec_io_checker.sv
`timescale 1ns/1ps
// Decoder I/O checker
// reference model of the rx queue, overflow flag, tx word queue and irq
// enable mask; compares bus reads, serial output words, serial clock
// phases and o_irq

module dec_io_checker import dec_bus_pkg::*, dec_tdm_pkg::*; (
	input logic clk,
	input logic i_reset,
	input logic i_dec_o,		// DUT serial out
	input logic i_dec_o_clk,
	input logic i_dec_o_fs,
	input logic i_irq
);

	code_t    code_q[$];	// codes held by the rx fifo
	pcm_t     pcm_q[$];	// words not yet seen on the serial line
	irq_vec_t en_model;
	logic     ovf_model;
	int       err_cnt, tests_run, tests_failed, test_err0, words_seen;
	logic     sclk_prev;
	pcm_t     word_sh;
	int       bit_n;
	int       sclk_phase;	// clk cycles in current serial clock phase

	initial begin
		en_model = '0;
		ovf_model = 1'b0;
		err_cnt = 0;
		tests_run = 0;
		tests_failed = 0;
		test_err0 = 0;
		words_seen = 0;
		sclk_prev = 1'b0;
		word_sh = '0;
		bit_n = 0;
		sclk_phase = -1;
	end

	task automatic check_value(input string what, input wb_dat_t got, input wb_dat_t exp);
		if (got !== exp) begin
			err_cnt++;
			$display("[FAIL] %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
		end
	endtask

	task automatic report_problem(input string msg);
		err_cnt++;
		$display("%s", msg);
	endtask

	// ----------------------------------------------------------
	// rx model
	task automatic sent_code(input code_t c);
		if (code_q.size() < FIFO_DEPTH)
			code_q.push_back(c);
		else
			ovf_model = 1'b1;	// dropped by a full fifo
	endtask

	function automatic wb_dat_t rx_status();
		return wb_dat_t'(code_q.size()) | (wb_dat_t'(ovf_model) << STAT_OVF_BIT);
	endfunction

	task automatic check_rx_data(input wb_dat_t got);
		wb_dat_t exp;
		exp = '0;	// empty fifo reads zero
		if (code_q.size() != 0)
			exp = wb_dat_t'(code_q.pop_front());
		check_value("rx data", got, exp);
	endtask

	task automatic clear_ovf();
		ovf_model = 1'b0;
	endtask

	// tx and irq model
	task automatic sent_pcm(input pcm_t w);
		pcm_q.push_back(w);
	endtask

	task automatic set_enable(input irq_vec_t en);
		en_model = en;
	endtask

	function automatic irq_vec_t sources();
		return {ovf_model, pcm_q.size() == 0, code_q.size() != 0};
	endfunction

	task automatic check_irq();
		check_value("o_irq", wb_dat_t'(i_irq), wb_dat_t'(|(sources() & en_model)));
	endtask

	// ----------------------------------------------------------
	// test bookkeeping
	task automatic begin_test();
		test_err0 = err_cnt;
		tests_run++;
	endtask

	task automatic end_test(input string name);
		if (err_cnt == test_err0) begin
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, err_cnt - test_err0);
		end
	endtask

	// serial monitor, sampled mid cycle on rising o_dec_o_clk
	always @(negedge clk) begin
		if (i_reset) begin
			bit_n = 0;
			sclk_phase = -1;	// first phase after reset is partial
		end else begin
			if (i_dec_o_clk != sclk_prev) begin	// serial clock edge
				if (sclk_phase >= 0)
					check_value("serial clock phase", wb_dat_t'(sclk_phase),
						wb_dat_t'(SER_DIV / 2));
				sclk_phase = 1;
			end else if (sclk_phase >= 0) begin
				sclk_phase++;
			end
			if (i_dec_o_clk && !sclk_prev) begin
				if (i_dec_o_fs) begin	// msb of a new word
					word_sh = pcm_t'(i_dec_o);
					bit_n = 1;
				end else if (bit_n > 0) begin
					word_sh = {word_sh[PCM_BITS-2:0], i_dec_o};
					bit_n++;
				end
				if (bit_n == PCM_BITS) begin
					bit_n = 0;
					words_seen++;
					if (pcm_q.size() == 0)
						report_problem("serial output sent a word that was never written");
					else
						check_value("tx word", wb_dat_t'(word_sh),
							wb_dat_t'(pcm_q.pop_front()));
				end
			end
		end
		sclk_prev = i_dec_o_clk;
	end

endmodule

// File: verilog/dec_io_top.sv
`timescale 1ns/1ps
// Decoder serial I/O top level
// one Wishbone slave port decoded onto the TDMI receiver, the TDMO
// transmitter and the interrupt controller, all on clk

module dec_io_top import dec_bus_pkg::*; (
	input  logic    clk,		// system clock
	input  logic    i_reset,	// sync, active high
	// Wishbone slave port
	input  wb_adr_t i_wb_adr,
	input  logic    i_wb_we,
	input  wb_dat_t i_wb_dat,
	input  logic    i_wb_cyc,
	input  logic    i_wb_stb,
	output wb_dat_t o_wb_dat,
	output logic    o_wb_ack,
	output logic    o_wb_err,
	// serial in, ADPCM codes
	input  logic    i_dec_s,
	input  logic    i_dec_s_clk,
	input  logic    i_dec_s_fs,
	// serial out, PCM words
	output logic    o_dec_o,
	output logic    o_dec_o_clk,
	output logic    o_dec_o_fs,
	output logic    o_irq
);

	// ----------------------------------------------------------
	// register side of the decoder
	logic     rx_sel, tx_sel, irq_sel;
	reg_ofs_t reg_ofs;
	logic     reg_we;
	wb_dat_t  reg_wdat;
	wb_dat_t  rx_rdat, tx_rdat, irq_rdat;
	logic     rx_ack, tx_ack, irq_ack;

	// status into the interrupt controller
	logic     rx_avail, rx_overflow, tx_empty;

	wb_slave_decoder wb_dec_inst0 (
		.clk(clk), .i_reset(i_reset),
		.i_wb_adr(i_wb_adr), .i_wb_we(i_wb_we), .i_wb_dat(i_wb_dat),
		.i_wb_cyc(i_wb_cyc), .i_wb_stb(i_wb_stb),
		.o_wb_dat(o_wb_dat), .o_wb_ack(o_wb_ack), .o_wb_err(o_wb_err),
		.o_rx_sel(rx_sel), .o_tx_sel(tx_sel), .o_irq_sel(irq_sel),
		.o_reg_ofs(reg_ofs), .o_we(reg_we), .o_wdat(reg_wdat),
		.i_rx_rdat(rx_rdat), .i_rx_ack(rx_ack),
		.i_tx_rdat(tx_rdat), .i_tx_ack(tx_ack),
		.i_irq_rdat(irq_rdat), .i_irq_ack(irq_ack)
	);

	tdm_rx tdmi_inst0 (
		.clk(clk), .i_reset(i_reset),
		.i_dec_s(i_dec_s), .i_dec_s_clk(i_dec_s_clk), .i_dec_s_fs(i_dec_s_fs),
		.i_sel(rx_sel), .i_reg_ofs(reg_ofs), .i_we(reg_we), .i_wdat(reg_wdat),
		.o_rdat(rx_rdat), .o_ack(rx_ack),
		.o_rx_avail(rx_avail), .o_rx_overflow(rx_overflow)
	);

	tdm_tx tdmo_inst0 (
		.clk(clk), .i_reset(i_reset),
		.i_sel(tx_sel), .i_reg_ofs(reg_ofs), .i_we(reg_we), .i_wdat(reg_wdat),
		.o_rdat(tx_rdat), .o_ack(tx_ack),
		.o_dec_o(o_dec_o), .o_dec_o_clk(o_dec_o_clk), .o_dec_o_fs(o_dec_o_fs),
		.o_tx_empty(tx_empty)
	);

	irq_ctrl irq_ctrl_inst0 (
		.clk(clk), .i_reset(i_reset),
		.i_sel(irq_sel), .i_reg_ofs(reg_ofs), .i_we(reg_we), .i_wdat(reg_wdat),
		.o_rdat(irq_rdat), .o_ack(irq_ack),
		.i_rx_avail(rx_avail), .i_tx_empty(tx_empty), .i_rx_overflow(rx_overflow),
		.o_irq(o_irq)
	);

endmodule

// File: verilog/irq_ctrl.sv
`timescale 1ns/1ps
// Interrupt controller
// raw status of the serial blocks, a 3 bit enable mask and one
// registered request line

module irq_ctrl import dec_bus_pkg::*, dec_tdm_pkg::*; (
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_sel,
	input  reg_ofs_t i_reg_ofs,
	input  logic     i_we,
	input  wb_dat_t  i_wdat,
	output wb_dat_t  o_rdat,
	output logic     o_ack,
	input  logic     i_rx_avail,	// from TDMI
	input  logic     i_tx_empty,	// from TDMO
	input  logic     i_rx_overflow,	// from TDMI
	output logic     o_irq
);

	irq_vec_t src;		// raw sources
	irq_vec_t enable;	// mask, reset to all off

	assign src[IRQ_RX_AVAIL] = i_rx_avail;
	assign src[IRQ_TX_EMPTY] = i_tx_empty;
	assign src[IRQ_RX_OVF]   = i_rx_overflow;

	// ----------------------------------------------------------
	// control state
	always_ff @(posedge clk) begin
		if (i_reset) begin
			enable <= '0;
			o_ack  <= 1'b0;
			o_irq  <= 1'b0;
		end else begin
			o_ack <= i_sel;
			o_irq <= |(src & enable);	// one cycle behind sources
			if (i_sel && i_we && i_reg_ofs == REG_IRQ_ENABLE)
				enable <= i_wdat[IRQ_SRC_BITS-1:0];
		end
	end

	// read data
	always_ff @(posedge clk) begin
		if (i_sel) begin
			case (i_reg_ofs)
				REG_IRQ_STATUS: o_rdat <= wb_dat_t'(src);
				REG_IRQ_ENABLE: o_rdat <= wb_dat_t'(enable);
				default:        o_rdat <= '0;
			endcase
		end
	end

endmodule

// File: verilog/tdm_tx.sv
`timescale 1ns/1ps
// TDMO serial transmitter
// queues PCM words written over the bus and shifts them out MSB first
// on a divided serial clock, frame sync marks the MSB bit period

module tdm_tx import dec_bus_pkg::*, dec_tdm_pkg::*; (
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_sel,
	input  reg_ofs_t i_reg_ofs,
	input  logic     i_we,
	input  wb_dat_t  i_wdat,
	output wb_dat_t  o_rdat,
	output logic     o_ack,
	output logic     o_dec_o,		// serial data
	output logic     o_dec_o_clk,		// generated serial clock
	output logic     o_dec_o_fs,		// high during msb
	output logic     o_tx_empty
);

	logic [DIV_CNT_BITS-1:0] div_cnt;
	logic                    sclk_q;
	logic                    half_tick;
	logic                    fall_tick;	// serial clock about to fall
	tx_state_t               state;
	logic [TX_CNT_BITS-1:0]  bit_cnt;
	logic                    last_bit;
	logic                    load;
	pcm_t                    shreg;
	logic                    fs_q;
	logic                    fifo_push;
	logic                    fifo_empty;
	logic                    fifo_full;
	pcm_t                    fifo_head;
	fifo_cnt_t               fifo_cnt;

	// ----------------------------------------------------------
	// serial clock, SER_DIV/2 low then SER_DIV/2 high, free running
	assign half_tick = (div_cnt == DIV_CNT_BITS'(SER_DIV / 2 - 1));
	assign fall_tick = half_tick && sclk_q;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			div_cnt <= '0;
			sclk_q  <= 1'b0;
		end else if (half_tick) begin
			div_cnt <= '0;
			sclk_q  <= ~sclk_q;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// shifter FSM, all changes on the falling serial edge
	assign last_bit = (bit_cnt == TX_CNT_BITS'(PCM_BITS - 1));
	assign load     = fall_tick && !fifo_empty && (state == TX_IDLE || last_bit);

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state   <= TX_IDLE;
			bit_cnt <= '0;
			shreg   <= '0;
			fs_q    <= 1'b0;
		end else if (fall_tick) begin
			if (load) begin		// new word, back to back if queued
				state   <= TX_SHIFT;
				bit_cnt <= '0;
				shreg   <= fifo_head;
				fs_q    <= 1'b1;
			end else if (state == TX_SHIFT && !last_bit) begin
				bit_cnt <= bit_cnt + 1'b1;
				shreg   <= {shreg[PCM_BITS-2:0], 1'b0};
				fs_q    <= 1'b0;
			end else begin
				state <= TX_IDLE;	// line parks low
				shreg <= '0;
				fs_q  <= 1'b0;
			end
		end
	end

	sample_fifo #(.WIDTH(PCM_BITS)) tx_fifo_inst0 (
		.clk     (clk),
		.i_reset (i_reset),
		.i_push  (fifo_push),
		.i_data  (i_wdat[PCM_BITS-1:0]),
		.i_pop   (load),
		.o_data  (fifo_head),
		.o_full  (fifo_full),
		.o_empty (fifo_empty),
		.o_count (fifo_cnt)
	);

	// ----------------------------------------------------------
	// registers
	assign fifo_push = i_sel && i_we && (i_reg_ofs == REG_DATA) && !fifo_full;	// full drops

	always_ff @(posedge clk) begin
		if (i_reset)
			o_ack <= 1'b0;
		else
			o_ack <= i_sel;
	end

	always_ff @(posedge clk) begin
		if (i_sel)
			o_rdat <= (i_reg_ofs == REG_STATUS) ? wb_dat_t'(fifo_cnt) : '0;
	end

	assign o_dec_o     = shreg[PCM_BITS-1];
	assign o_dec_o_clk = sclk_q;
	assign o_dec_o_fs  = fs_q;
	assign o_tx_empty  = fifo_empty && (state == TX_IDLE);

endmodule

// File: verilog/tdm_rx.sv
`timescale 1ns/1ps
// TDMI serial receiver
// samples the external serial clock, shifts in 8 bit ADPCM code words
// after each frame sync and queues them for the bus, with a sticky
// overflow flag when the queue is full

module tdm_rx import dec_bus_pkg::*, dec_tdm_pkg::*; (
	input  logic     clk,
	input  logic     i_reset,
	input  logic     i_dec_s,		// serial data, MSB first
	input  logic     i_dec_s_clk,		// external serial clock
	input  logic     i_dec_s_fs,		// frame sync
	input  logic     i_sel,
	input  reg_ofs_t i_reg_ofs,
	input  logic     i_we,
	input  wb_dat_t  i_wdat,		// data ignored, any status write clears
	output wb_dat_t  o_rdat,
	output logic     o_ack,
	output logic     o_rx_avail,
	output logic     o_rx_overflow
);

	logic [2:0]             sync_meta;	// {fs, sclk, data} first stage
	logic [2:0]             sync_q;		// second stage
	logic                   sclk_prev;
	logic                   sclk_rise;
	rx_state_t              state;
	logic [RX_CNT_BITS-1:0] bit_cnt;
	code_t                  shreg;
	logic                   push_q;		// word complete, push next cycle
	logic                   ovf;
	logic                   fifo_full;
	logic                   fifo_empty;
	logic                   fifo_pop;
	code_t                  fifo_head;
	fifo_cnt_t              fifo_cnt;

	// ----------------------------------------------------------
	// input sync, data and fs ride along with the clock
	always_ff @(posedge clk) begin
		if (i_reset) begin
			sync_meta <= '0;
			sync_q    <= '0;
			sclk_prev <= 1'b0;
		end else begin
			sync_meta <= {i_dec_s_fs, i_dec_s_clk, i_dec_s};
			sync_q    <= sync_meta;
			sclk_prev <= sync_q[1];
		end
	end

	assign sclk_rise = sync_q[1] && !sclk_prev;

	// bit counting FSM
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state   <= RX_IDLE;
			bit_cnt <= '0;
			push_q  <= 1'b0;
		end else begin
			push_q <= 1'b0;
			if (sclk_rise) begin
				case (state)
					RX_IDLE: begin
						if (sync_q[2]) begin	// fs seen, frame starts next edge
							state   <= RX_SHIFT;
							bit_cnt <= '0;
						end
					end
					RX_SHIFT: begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == RX_CNT_BITS'(CODE_BITS - 1)) begin
							state  <= RX_IDLE;
							push_q <= 1'b1;
						end
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sclk_rise && state == RX_SHIFT)
			shreg <= {shreg[CODE_BITS-2:0], sync_q[0]};	// msb first
	end

	sample_fifo #(.WIDTH(CODE_BITS)) rx_fifo_inst0 (
		.clk     (clk),
		.i_reset (i_reset),
		.i_push  (push_q),
		.i_data  (shreg),
		.i_pop   (fifo_pop),
		.o_data  (fifo_head),
		.o_full  (fifo_full),
		.o_empty (fifo_empty),
		.o_count (fifo_cnt)
	);

	// ----------------------------------------------------------
	// registers
	assign fifo_pop = i_sel && !i_we && (i_reg_ofs == REG_DATA);	// read pops

	always_ff @(posedge clk) begin
		if (i_reset) begin
			ovf   <= 1'b0;
			o_ack <= 1'b0;
		end else begin
			o_ack <= i_sel;
			if (push_q && fifo_full)
				ovf <= 1'b1;	// word dropped
			else if (i_sel && i_we && i_reg_ofs == REG_STATUS)
				ovf <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_sel) begin
			case (i_reg_ofs)
				REG_DATA:   o_rdat <= fifo_empty ? '0 : wb_dat_t'(fifo_head);
				REG_STATUS: o_rdat <= wb_dat_t'(fifo_cnt) | (wb_dat_t'(ovf) << STAT_OVF_BIT);
				default:    o_rdat <= '0;
			endcase
		end
	end

	assign o_rx_avail    = !fifo_empty;
	assign o_rx_overflow = ovf;

endmodule

// File: verilog/wb_slave_decoder.sv
`timescale 1ns/1ps
// Wishbone slave decoder
// splits the classic bus port into one register strobe per block,
// muxes back read data and ack of the addressed block and answers
// unmapped slave numbers with a registered err

module wb_slave_decoder import dec_bus_pkg::*; (
	input  logic     clk,
	input  logic     i_reset,
	// external master
	input  wb_adr_t  i_wb_adr,
	input  logic     i_wb_we,
	input  wb_dat_t  i_wb_dat,
	input  logic     i_wb_cyc,
	input  logic     i_wb_stb,
	output wb_dat_t  o_wb_dat,
	output logic     o_wb_ack,
	output logic     o_wb_err,
	// register side, shared by all blocks
	output logic     o_rx_sel,
	output logic     o_tx_sel,
	output logic     o_irq_sel,
	output reg_ofs_t o_reg_ofs,
	output logic     o_we,
	output wb_dat_t  o_wdat,
	input  wb_dat_t  i_rx_rdat,
	input  logic     i_rx_ack,
	input  wb_dat_t  i_tx_rdat,
	input  logic     i_tx_ack,
	input  wb_dat_t  i_irq_rdat,
	input  logic     i_irq_ack
);

	logic [SLV_SEL_BITS-1:0] slv;		// slave field of current address
	logic [SLV_SEL_BITS-1:0] slv_q;		// slave of access in flight
	logic                    busy;		// strobe given, waiting for response
	logic                    err_q;
	logic                    new_acc;
	logic                    mapped;

	assign slv     = i_wb_adr[SLV_SEL_LSB +: SLV_SEL_BITS];
	assign new_acc = i_wb_cyc && i_wb_stb && !busy;
	assign mapped  = (slv == SLV_TDM_RX) || (slv == SLV_TDM_TX) || (slv == SLV_IRQ);

	// one strobe per access
	assign o_rx_sel  = new_acc && (slv == SLV_TDM_RX);
	assign o_tx_sel  = new_acc && (slv == SLV_TDM_TX);
	assign o_irq_sel = new_acc && (slv == SLV_IRQ);
	assign o_reg_ofs = i_wb_adr[REG_OFS_LSB +: $bits(reg_ofs_t)];
	assign o_we      = i_wb_we;
	assign o_wdat    = i_wb_dat;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			busy  <= 1'b0;
			slv_q <= SLV_TDM_RX;
			err_q <= 1'b0;
		end else begin
			err_q <= new_acc && !mapped;	// err one cycle after request
			if (new_acc) begin
				busy  <= 1'b1;
				slv_q <= slv;
			end else if (o_wb_ack || o_wb_err) begin
				busy <= 1'b0;
			end
		end
	end

	assign o_wb_err = err_q;

	// ----------------------------------------------------------
	// response mux
	always_comb begin
		o_wb_dat = '0;
		o_wb_ack = 1'b0;
		case (slv_q)
			SLV_TDM_RX: begin
				o_wb_dat = i_rx_rdat;
				o_wb_ack = i_rx_ack;
			end
			SLV_TDM_TX: begin
				o_wb_dat = i_tx_rdat;
				o_wb_ack = i_tx_ack;
			end
			SLV_IRQ: begin
				o_wb_dat = i_irq_rdat;
				o_wb_ack = i_irq_ack;
			end
			default: o_wb_ack = 1'b0;	// unmapped, err path answers
		endcase
	end

endmodule

// File: verilog/sample_fifo.sv
`timescale 1ns/1ps
// Sample FIFO
// small circular buffer shared by the serial blocks, head word is
// shown on the output, push when full and pop when empty are ignored

module sample_fifo import dec_tdm_pkg::*; #(
	parameter int WIDTH = 8
) (
	input  logic             clk,		// system clock
	input  logic             i_reset,	// sync, active high
	input  logic             i_push,
	input  logic [WIDTH-1:0] i_data,
	input  logic             i_pop,
	output logic [WIDTH-1:0] o_data,	// head of queue
	output logic             o_full,
	output logic             o_empty,
	output fifo_cnt_t        o_count	// words held
);

	logic [WIDTH-1:0]         mem [FIFO_DEPTH];	// storage
	logic [FIFO_PTR_BITS-1:0] wr_ptr;
	logic [FIFO_PTR_BITS-1:0] rd_ptr;
	fifo_cnt_t                count;
	logic                     do_push;
	logic                     do_pop;

	assign do_push = i_push && !o_full;
	assign do_pop  = i_pop && !o_empty;

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;	// idle or push+pop
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= i_data;
	end

	assign o_data  = mem[rd_ptr];
	assign o_full  = (count == fifo_cnt_t'(FIFO_DEPTH));
	assign o_empty = (count == '0);
	assign o_count = count;

endmodule

// File: verilog/dec_tdm_pkg.sv
// TDM serial definitions
// code and PCM word widths, sample FIFO sizing, transmit clock divider,
// interrupt source layout and the serial state machine encodings

package dec_tdm_pkg;

	// ----------------------------------------------------------
	// frame words
	localparam int CODE_BITS = 8;	// ADPCM code word in
	localparam int PCM_BITS  = 16;	// PCM word out

	typedef logic [CODE_BITS-1:0] code_t;
	typedef logic [PCM_BITS-1:0]  pcm_t;

	localparam int RX_CNT_BITS = $clog2(CODE_BITS);	// rx bit counter
	localparam int TX_CNT_BITS = $clog2(PCM_BITS);	// tx bit counter

	// ----------------------------------------------------------
	// sample fifo
	localparam int FIFO_DEPTH    = 4;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);
	typedef logic [FIFO_PTR_BITS:0] fifo_cnt_t;	// holds 0..FIFO_DEPTH

	// tx serial clock, clk cycles per bit
	localparam int SER_DIV      = 4;
	localparam int DIV_CNT_BITS = $clog2(SER_DIV);

	// ----------------------------------------------------------
	// interrupt sources
	localparam int IRQ_SRC_BITS = 3;
	typedef logic [IRQ_SRC_BITS-1:0] irq_vec_t;
	localparam int IRQ_RX_AVAIL = 0;	// rx code word waiting
	localparam int IRQ_TX_EMPTY = 1;	// tx fifo and shifter drained
	localparam int IRQ_RX_OVF   = 2;	// rx word lost

	typedef enum logic {RX_IDLE, RX_SHIFT} rx_state_t;
	typedef enum logic {TX_IDLE, TX_SHIFT} tx_state_t;

endpackage

// File: verilog/dec_bus_pkg.sv
// Decoder I/O bus definitions
// Wishbone widths, slave address map and register offsets of the
// serial receive, serial transmit and interrupt blocks

package dec_bus_pkg;

	// ----------------------------------------------------------
	// bus widths
	localparam int WB_AWIDTH = 32;	// byte address
	localparam int WB_DWIDTH = 32;	// full word accesses only

	typedef logic [WB_AWIDTH-1:0] wb_adr_t;
	typedef logic [WB_DWIDTH-1:0] wb_dat_t;

	// ----------------------------------------------------------
	// slave map, one 256 byte window per slave
	localparam int SLV_SEL_LSB  = 8;	// adr[11:8] picks the slave
	localparam int SLV_SEL_BITS = 4;

	localparam logic [SLV_SEL_BITS-1:0] SLV_TDM_RX = 4'd0;	// TDMI
	localparam logic [SLV_SEL_BITS-1:0] SLV_TDM_TX = 4'd1;	// TDMO
	localparam logic [SLV_SEL_BITS-1:0] SLV_IRQ    = 4'd2;	// interrupt controller
	// 3..15 unmapped, answered with err

	// ----------------------------------------------------------
	// register offsets inside a window
	localparam int REG_OFS_LSB = 2;	// word offset in adr[3:2]
	typedef logic [1:0] reg_ofs_t;

	localparam reg_ofs_t REG_DATA       = 2'd0;	// serial blocks
	localparam reg_ofs_t REG_STATUS     = 2'd1;
	localparam reg_ofs_t REG_IRQ_STATUS = 2'd0;	// interrupt controller
	localparam reg_ofs_t REG_IRQ_ENABLE = 2'd1;

	localparam int STAT_OVF_BIT = 8;	// sticky rx overflow in rx status

endpackage
